// ==== hw/instr_fields_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface instr_fields_if import mips_pkg::*; ();
  opcode_t opcode;
  funct_t funct;
  regaddr_t rs;
  regaddr_t rt;
  regaddr_t rd;
  logic [15:0] immediate;
  logic [25:0] target;

  modport producer(output opcode, funct, rs, rt, rd, immediate, target);
  modport consumer(input opcode, funct, rs, rt, rd, immediate, target);
endinterface

`default_nettype wire

// ==== hw/mips_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_alu import mips_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  state_t  state_i,
  instr_fields_if.consumer fields,
  input  alu_op_t alu_op_i,
  input  logic    alu_src_imm_i,
  input  logic    imm_zero_ext_i,
  input  word_t   rs_i,
  input  word_t   rt_i,
  output word_t   result_o,
  output logic    eq_o
);

  word_t rs_q;
  word_t rt_q;
  word_t imm_q;
  word_t imm_ext;
  word_t op_b;

  assign imm_ext = imm_zero_ext_i ? {16'h0000, fields.immediate}
                                  : {{16{fields.immediate[15]}}, fields.immediate};

  // Operands are captured once per instruction, at the end of DECODE
  always_ff @(posedge clk) begin
    if (reset) begin
      rs_q  <= '0;
      rt_q  <= '0;
      imm_q <= '0;
    end else if (state_i == DECODE) begin
      rs_q  <= rs_i;
      rt_q  <= rt_i;
      imm_q <= imm_ext;
    end
  end

  assign op_b = alu_src_imm_i ? imm_q : rt_q;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_o = rs_q + op_b;
      ALU_SUB:  result_o = rs_q - op_b;
      ALU_AND:  result_o = rs_q & op_b;
      ALU_OR:   result_o = rs_q | op_b;
      ALU_XOR:  result_o = rs_q ^ op_b;
      ALU_SLTU: result_o = {31'b0, rs_q < op_b};
      ALU_LUI:  result_o = {imm_q[15:0], 16'h0000};
      default:  result_o = rs_q + op_b;
    endcase
  end

  // Branch compare uses the registered rs and rt
  assign eq_o = rs_q == rt_q;

endmodule

`default_nettype wire

// ==== hw/mips_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_control import mips_pkg::*; (
  input  state_t    state_i,
  instr_fields_if.consumer fields,
  input  logic      eq_i,
  output logic      pc_write_en_o,
  output logic      ir_write_en_o,
  output logic      regfile_write_en_o,
  output logic      read_o,
  output logic      write_o,
  output logic      mem_addr_sel_o,
  output logic      alu_src_imm_o,
  output logic      imm_zero_ext_o,
  output logic      branch_taken_o,
  output logic      mem_access_o,
  output logic      writeback_o,
  output dest_sel_t dest_sel_o,
  output alu_op_t   alu_op_o
);

  logic is_special;
  logic is_jr;
  logic is_branch;
  logic is_load;
  logic is_store;
  logic r_type_alu;

  assign is_special = fields.opcode == OP_SPECIAL;
  assign is_jr      = is_special && fields.funct == FN_JR;
  assign is_branch  = fields.opcode == OP_BEQ || fields.opcode == OP_BNE;
  assign is_load    = fields.opcode == OP_LW;
  assign is_store   = fields.opcode == OP_SW;

  // Only the supported R-type ALU functions write a register
  assign r_type_alu = is_special && (fields.funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR,
                                                         FN_XOR, FN_SLTU});

  assign branch_taken_o = (fields.opcode == OP_BEQ && eq_i) ||
                          (fields.opcode == OP_BNE && !eq_i);

  assign mem_access_o = is_load || is_store;
  assign writeback_o  = r_type_alu || is_load || fields.opcode inside {OP_ADDIU, OP_ORI, OP_LUI};

  assign alu_src_imm_o  = !is_special && !is_branch;
  assign imm_zero_ext_o = fields.opcode == OP_ORI;
  assign dest_sel_o     = is_special ? DEST_RD : DEST_RT;

  always_comb begin
    alu_op_o = ALU_ADD;
    case (fields.opcode)
      OP_SPECIAL: begin
        case (fields.funct)
          FN_SUBU: alu_op_o = ALU_SUB;
          FN_AND:  alu_op_o = ALU_AND;
          FN_OR:   alu_op_o = ALU_OR;
          FN_XOR:  alu_op_o = ALU_XOR;
          FN_SLTU: alu_op_o = ALU_SLTU;
          default: alu_op_o = ALU_ADD;
        endcase
      end
      OP_ORI:  alu_op_o = ALU_OR;
      OP_LUI:  alu_op_o = ALU_LUI;
      default: alu_op_o = ALU_ADD;
    endcase
  end

  // Per-state enables
  assign ir_write_en_o      = state_i == FETCH;
  assign pc_write_en_o      = state_i == FETCH ||
                              (state_i == EXEC && (fields.opcode == OP_J || is_jr ||
                                                   (is_branch && branch_taken_o)));
  assign read_o             = state_i == FETCH || (state_i == MEM && is_load);
  assign write_o            = state_i == MEM && is_store;
  assign mem_addr_sel_o     = state_i == MEM;
  assign regfile_write_en_o = state_i == WRITEBACK;

endmodule

`default_nettype wire

// ==== hw/mips_cpu_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_bus import mips_pkg::*; #(
  parameter word_t RESET_VECTOR = 32'hBFC0_0000
) (
  input  logic       clk,
  input  logic       reset,
  output logic       active_o,
  output word_t      register_v0_o,
  output word_t      address_o,
  output logic       write_o,
  output logic       read_o,
  input  logic       waitrequest_i,
  output word_t      writedata_o,
  output logic [3:0] byteenable_o,
  input  word_t      readdata_i
);

  // Bus is little-endian, the core is big-endian
  function automatic word_t swap_bytes(word_t w);
    swap_bytes = {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  instr_fields_if fields ();

  state_t    state;
  logic      pc_write_en;
  logic      ir_write_en;
  logic      regfile_write_en;
  logic      ctl_read;
  logic      ctl_write;
  logic      mem_addr_sel;
  logic      alu_src_imm;
  logic      imm_zero_ext;
  logic      branch_taken;
  logic      mem_access;
  logic      writeback;
  logic      jump_to_zero;
  logic      eq;
  logic      bus_wait;
  dest_sel_t dest_sel;
  alu_op_t   alu_op;
  word_t     readdata_be;
  word_t     pc;
  word_t     rs_data;
  word_t     rt_data;
  word_t     alu_result;
  word_t     load_q;
  word_t     wb_data;
  regaddr_t  wr_addr;

  assign readdata_be = swap_bytes(readdata_i);

  // An access that is still waiting freezes the PC and IR
  assign bus_wait = (ctl_read || ctl_write) && waitrequest_i;

  mips_fsm u_fsm (
    .clk            (clk),
    .reset          (reset),
    .waitrequest_i  (waitrequest_i),
    .mem_access_i   (mem_access),
    .writeback_i    (writeback),
    .jump_to_zero_i (jump_to_zero),
    .state_o        (state)
  );

  mips_control u_control (
    .state_i            (state),
    .fields             (fields),
    .eq_i               (eq),
    .pc_write_en_o      (pc_write_en),
    .ir_write_en_o      (ir_write_en),
    .regfile_write_en_o (regfile_write_en),
    .read_o             (ctl_read),
    .write_o            (ctl_write),
    .mem_addr_sel_o     (mem_addr_sel),
    .alu_src_imm_o      (alu_src_imm),
    .imm_zero_ext_o     (imm_zero_ext),
    .branch_taken_o     (branch_taken),
    .mem_access_o       (mem_access),
    .writeback_o        (writeback),
    .dest_sel_o         (dest_sel),
    .alu_op_o           (alu_op)
  );

  mips_ir u_ir (
    .clk     (clk),
    .reset   (reset),
    .wen_i   (ir_write_en && !bus_wait),
    .instr_i (readdata_be),
    .fields  (fields)
  );

  mips_pc #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_pc (
    .clk            (clk),
    .reset          (reset),
    .state_i        (state),
    .wen_i          (pc_write_en && !bus_wait),
    .branch_taken_i (branch_taken),
    .fields         (fields),
    .rs_data_i      (rs_data),
    .pc_o           (pc),
    .jump_to_zero_o (jump_to_zero)
  );

  assign wr_addr = (dest_sel == DEST_RD) ? fields.rd : fields.rt;
  assign wb_data = (fields.opcode == OP_LW) ? load_q : alu_result;

  mips_regfile u_regfile (
    .clk       (clk),
    .reset     (reset),
    .rs_addr_i (fields.rs),
    .rt_addr_i (fields.rt),
    .wr_addr_i (wr_addr),
    .wr_data_i (wb_data),
    .wen_i     (regfile_write_en),
    .rs_data_o (rs_data),
    .rt_data_o (rt_data),
    .v0_o      (register_v0_o)
  );

  mips_alu u_alu (
    .clk            (clk),
    .reset          (reset),
    .state_i        (state),
    .fields         (fields),
    .alu_op_i       (alu_op),
    .alu_src_imm_i  (alu_src_imm),
    .imm_zero_ext_i (imm_zero_ext),
    .rs_i           (rs_data),
    .rt_i           (rt_data),
    .result_o       (alu_result),
    .eq_o           (eq)
  );

  // Load data for WRITEBACK
  always_ff @(posedge clk) begin
    if (state == MEM && ctl_read && !waitrequest_i) begin
      load_q <= readdata_be;
    end
  end

  // Bus strobes stay low while reset is held
  assign read_o       = ctl_read && !reset;
  assign write_o      = ctl_write && !reset;
  assign address_o    = mem_addr_sel ? alu_result : pc;
  assign writedata_o  = swap_bytes(rt_data);
  assign byteenable_o = 4'b1111;
  assign active_o     = state != HALT;

endmodule

`default_nettype wire

// ==== hw/mips_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_fsm import mips_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   waitrequest_i,
  input  logic   mem_access_i,
  input  logic   writeback_i,
  input  logic   jump_to_zero_i,
  output state_t state_o
);

  state_t state_q;
  state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH: begin
        if (!waitrequest_i) begin
          state_d = DECODE;
        end
      end
      DECODE: state_d = EXEC;
      EXEC: begin
        // A jump or branch to address 0 ends the program
        if (jump_to_zero_i) begin
          state_d = HALT;
        end else if (mem_access_i) begin
          state_d = MEM;
        end else if (writeback_i) begin
          state_d = WRITEBACK;
        end else begin
          state_d = FETCH;
        end
      end
      MEM: begin
        if (!waitrequest_i) begin
          state_d = writeback_i ? WRITEBACK : FETCH;
        end
      end
      WRITEBACK: state_d = FETCH;
      HALT: state_d = HALT;
      default: state_d = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

// ==== hw/mips_ir.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_ir import mips_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  wen_i,
  input  word_t instr_i,
  instr_fields_if.producer fields
);

  word_t instr_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      // All zeros decodes as SLL $0, which does nothing
      instr_q <= '0;
    end else if (wen_i) begin
      instr_q <= instr_i;
    end
  end

  assign fields.opcode    = opcode_t'(instr_q[31:26]);
  assign fields.rs        = instr_q[25:21];
  assign fields.rt        = instr_q[20:16];
  assign fields.rd        = instr_q[15:11];
  assign fields.funct     = funct_t'(instr_q[5:0]);
  assign fields.immediate = instr_q[15:0];
  assign fields.target    = instr_q[25:0];

endmodule

`default_nettype wire

// ==== hw/mips_pc.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_pc import mips_pkg::*; #(
  parameter word_t RESET_VECTOR = 32'hBFC0_0000
) (
  input  logic   clk,
  input  logic   reset,
  input  state_t state_i,
  input  logic   wen_i,
  input  logic   branch_taken_i,
  instr_fields_if.consumer fields,
  input  word_t  rs_data_i,
  output word_t  pc_o,
  output logic   jump_to_zero_o
);

  word_t pc_q;
  word_t next_pc;
  word_t branch_offset;

  // In EXEC the PC already points past the branch
  assign branch_offset = {{14{fields.immediate[15]}}, fields.immediate, 2'b00};

  always_comb begin
    next_pc = pc_q;
    if (state_i == FETCH) begin
      next_pc = pc_q + 32'd4;
    end else if (state_i == EXEC) begin
      if (fields.opcode == OP_J) begin
        next_pc = {pc_q[31:28], fields.target, 2'b00};
      end else if (fields.opcode == OP_SPECIAL && fields.funct == FN_JR) begin
        next_pc = rs_data_i;
      end else if (branch_taken_i) begin
        next_pc = pc_q + branch_offset;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= RESET_VECTOR;
    end else if (wen_i) begin
      pc_q <= next_pc;
    end
  end

  assign pc_o           = pc_q;
  assign jump_to_zero_o = wen_i && next_pc == 32'h0;

endmodule

`default_nettype wire

// ==== hw/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regaddr_t;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXEC,
    MEM,
    WRITEBACK,
    HALT
  } state_t;

  // Primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0D,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // Function codes for SPECIAL, instr[5:0]
  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLTU = 6'h2B
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLTU,
    ALU_LUI
  } alu_op_t;

  typedef enum logic {
    DEST_RD,
    DEST_RT
  } dest_sel_t;

endpackage

`default_nettype wire

// ==== hw/mips_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_regfile import mips_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  regaddr_t rs_addr_i,
  input  regaddr_t rt_addr_i,
  input  regaddr_t wr_addr_i,
  input  word_t    wr_data_i,
  input  logic     wen_i,
  output word_t    rs_data_o,
  output word_t    rt_data_o,
  output word_t    v0_o
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && wr_addr_i != 5'd0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // Register 0 is never written so it reads as zero
  assign rs_data_o = regs[rs_addr_i];
  assign rt_data_o = regs[rt_addr_i];
  assign v0_o      = regs[2];

endmodule

`default_nettype wire

// ==== sim/avalon_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module avalon_mem_model #(
  parameter logic [31:0] BASE_ADDR = 32'h0000_1000,
  parameter int          DEPTH     = 256
) (
  input  logic        clk,
  input  logic [31:0] address_i,
  input  logic        write_i,
  input  logic [31:0] writedata_i,
  input  logic [3:0]  byteenable_i,
  output logic        waitrequest_o,
  output logic [31:0] readdata_o,
  output logic [31:0] last_wr_addr_o,
  output logic [31:0] last_wr_data_o,
  output logic [3:0]  last_wr_be_o,
  output int          wr_count_o
);

  // Words are kept as they appear on the little-endian bus
  logic [31:0] mem [DEPTH];
  int seed;
  int wr_index;

  function automatic int word_index(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - BASE_ADDR;
    word_index = int'((offset >> 2) % DEPTH);
  endfunction

  initial begin
    seed           = 32'h9984_9fd8;
    waitrequest_o  = 1'b0;
    readdata_o     = '0;
    last_wr_addr_o = '0;
    last_wr_data_o = '0;
    last_wr_be_o   = '0;
    wr_count_o     = 0;
  end

  // New response each cycle driven just after the rising edge
  always @(posedge clk) begin
    #1;
    // Stall on about one cycle in four
    waitrequest_o = ($random(seed) & 3) == 0;
    readdata_o    = mem[word_index(address_i)];
  end

  // A write whose waitrequest is low completes at the coming edge
  always @(negedge clk) begin
    if (write_i && !waitrequest_o) begin
      wr_index = word_index(address_i);
      for (int b = 0; b < 4; b++) begin
        if (byteenable_i[b]) begin
          mem[wr_index][8*b +: 8] = writedata_i[8*b +: 8];
        end
      end
      last_wr_addr_o = address_i;
      last_wr_data_o = writedata_i;
      last_wr_be_o   = byteenable_i;
      wr_count_o     = wr_count_o + 1;
      $display("Bus write to %h: data %h byteenable %b", address_i, writedata_i, byteenable_i);
    end
  end

endmodule

`default_nettype wire

// ==== sim/mips_cpu_bus_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_bus_tb;

  localparam logic [31:0] RESET_VECTOR   = 32'h0000_1000;
  localparam int          MEM_WORDS      = 256;
  localparam logic [31:0] DATA_ADDR      = RESET_VECTOR + 32'h200;
  localparam logic [31:0] SUM_ADDR       = DATA_ADDR + 32'd16;
  localparam int          DATA_WORD      = 128;
  localparam int          JR_INDEX       = 24;
  localparam int          RESET_CYCLES   = 5;
  // Up to 5 cycles for each of about 40 instructions and ten times that for wait cycles
  localparam int          TIMEOUT_CYCLES = 40 * 5 * 10;

  // MIPS-I encodings
  localparam logic [5:0] OPC_J     = 6'h02;
  localparam logic [5:0] OPC_BEQ   = 6'h04;
  localparam logic [5:0] OPC_BNE   = 6'h05;
  localparam logic [5:0] OPC_ADDIU = 6'h09;
  localparam logic [5:0] OPC_ORI   = 6'h0D;
  localparam logic [5:0] OPC_LUI   = 6'h0F;
  localparam logic [5:0] OPC_LW    = 6'h23;
  localparam logic [5:0] OPC_SW    = 6'h2B;
  localparam logic [5:0] FN_JR     = 6'h08;
  localparam logic [5:0] FN_ADDU   = 6'h21;
  localparam logic [5:0] FN_SUBU   = 6'h23;
  localparam logic [5:0] FN_AND    = 6'h24;
  localparam logic [5:0] FN_OR     = 6'h25;
  localparam logic [5:0] FN_XOR    = 6'h26;
  localparam logic [5:0] FN_SLTU   = 6'h2B;

  // D2 is below D3 only when compared unsigned
  localparam logic [31:0] D0 = 32'h1234_5678;
  localparam logic [31:0] D1 = 32'h0BAD_F00D;
  localparam logic [31:0] D2 = 32'h0000_0FFF;
  localparam logic [31:0] D3 = 32'h8000_0001;

  logic        clk;
  logic        reset;
  logic        bus_active;
  logic [31:0] register_v0;
  logic [31:0] bus_address;
  logic        bus_write;
  logic        bus_read;
  logic        bus_waitrequest;
  logic [31:0] bus_writedata;
  logic [3:0]  bus_byteenable;
  logic [31:0] bus_readdata;
  logic [31:0] last_wr_addr;
  logic [31:0] last_wr_data;
  logic [3:0]  last_wr_be;
  int          wr_count;
  logic        req_pending;
  logic [31:0] held_address;
  logic        held_read;
  logic        held_write;
  logic        first_read_seen;
  logic [31:0] last_fetch_addr;
  logic [31:0] exp_sum;
  logic [31:0] exp_checksum;
  int          cycles;

  tb_clock_gen #(.PERIOD_NS(8.0)) u_clk (.clk_o(clk));

  avalon_mem_model #(
    .BASE_ADDR (RESET_VECTOR),
    .DEPTH     (MEM_WORDS)
  ) u_mem (
    .clk            (clk),
    .address_i      (bus_address),
    .write_i        (bus_write),
    .writedata_i    (bus_writedata),
    .byteenable_i   (bus_byteenable),
    .waitrequest_o  (bus_waitrequest),
    .readdata_o     (bus_readdata),
    .last_wr_addr_o (last_wr_addr),
    .last_wr_data_o (last_wr_data),
    .last_wr_be_o   (last_wr_be),
    .wr_count_o     (wr_count)
  );

  mips_cpu_bus #(.RESET_VECTOR(RESET_VECTOR)) UUT (
    .clk           (clk),
    .reset         (reset),
    .active_o      (bus_active),
    .register_v0_o (register_v0),
    .address_o     (bus_address),
    .write_o       (bus_write),
    .read_o        (bus_read),
    .waitrequest_i (bus_waitrequest),
    .writedata_o   (bus_writedata),
    .byteenable_o  (bus_byteenable),
    .readdata_i    (bus_readdata)
  );

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    stop_on_error($sformatf("MISMATCH at %0t: %s", $time, msg));
  endtask

  function automatic logic [31:0] swap_endian(input logic [31:0] w);
    swap_endian = {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic [31:0] r_type(input int rs, input int rt, input int rd,
                                         input logic [5:0] funct);
    r_type = {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input int rs, input int rt,
                                         input logic [15:0] imm);
    i_type = {op, rs[4:0], rt[4:0], imm};
  endfunction

  // Without a delay slot the offset counts from the next instruction
  function automatic logic [15:0] branch_offset(input int from_index, input int to_index);
    branch_offset = 16'(to_index - from_index - 1);
  endfunction

  function automatic logic [31:0] j_type(input int to_index);
    logic [31:0] addr;
    addr = RESET_VECTOR + 32'(to_index * 4);
    j_type = {OPC_J, addr[27:2]};
  endfunction

  function automatic logic [31:0] expected_checksum(input logic [31:0] sum);
    logic [31:0] chk;
    chk = (sum & (32'h00FF_0000 | 32'h0000_F0F0)) ^ D0;
    chk = chk + ((D2 < D3) ? 32'd1 : 32'd0);
    // Loop counter runs 3, 2, 1
    for (int count = 3; count > 0; count--) begin
      chk = chk + 32'h0111 - 32'(count);
    end
    expected_checksum = chk;
  endfunction

  task automatic load_memory();
    logic [31:0] prog [25];
    for (int i = 0; i < MEM_WORDS; i++) begin
      // Unused words hold a pattern of the whole word index
      u_mem.mem[i] = {8'hEE, i[7:0] ^ 8'h5A, ~i[7:0], i[7:0]};
    end
    prog[0]  = i_type(OPC_ORI, 0, 8, DATA_ADDR[15:0]);
    prog[1]  = i_type(OPC_LW, 8, 9, 16'd0);
    prog[2]  = i_type(OPC_LW, 8, 10, 16'd4);
    prog[3]  = i_type(OPC_LW, 8, 11, 16'd8);
    prog[4]  = i_type(OPC_LW, 8, 12, 16'd12);
    prog[5]  = r_type(9, 10, 13, FN_ADDU);
    prog[6]  = r_type(13, 11, 13, FN_ADDU);
    prog[7]  = r_type(13, 12, 13, FN_ADDU);
    prog[8]  = i_type(OPC_LUI, 0, 14, 16'h00FF);
    prog[9]  = i_type(OPC_ORI, 14, 14, 16'hF0F0);
    prog[10] = r_type(13, 14, 15, FN_AND);
    prog[11] = r_type(15, 9, 15, FN_XOR);
    prog[12] = r_type(11, 12, 16, FN_SLTU);
    prog[13] = r_type(15, 16, 15, FN_ADDU);
    prog[14] = i_type(OPC_ORI, 0, 17, 16'd3);
    // Loop body
    prog[15] = i_type(OPC_ADDIU, 15, 15, 16'h0111);
    prog[16] = r_type(15, 17, 15, FN_SUBU);
    prog[17] = i_type(OPC_ADDIU, 17, 17, 16'hFFFF);
    prog[18] = i_type(OPC_BNE, 17, 0, branch_offset(18, 15));
    // Never taken because D0 and D1 differ
    prog[19] = i_type(OPC_BEQ, 9, 10, branch_offset(19, 21));
    prog[20] = j_type(22);
    // Poison that must be skipped
    prog[21] = i_type(OPC_ADDIU, 15, 15, 16'h7777);
    prog[22] = i_type(OPC_SW, 8, 13, 16'd16);
    prog[23] = r_type(15, 0, 2, FN_OR);
    prog[24] = r_type(0, 0, 0, FN_JR);
    for (int i = 0; i < 25; i++) begin
      u_mem.mem[i] = swap_endian(prog[i]);
    end
    u_mem.mem[DATA_WORD]     = swap_endian(D0);
    u_mem.mem[DATA_WORD + 1] = swap_endian(D1);
    u_mem.mem[DATA_WORD + 2] = swap_endian(D2);
    u_mem.mem[DATA_WORD + 3] = swap_endian(D3);
  endtask

  // Bus checks sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    if (!reset) begin
      assert (!(bus_read && bus_write)) else report_mismatch("read and write both high");
      if (req_pending) begin
        assert (bus_address == held_address && bus_read == held_read &&
                bus_write == held_write)
        else report_mismatch("bus request changed while waitrequest was high");
      end
      if (bus_write) begin
        assert (bus_byteenable == 4'hF)
        else report_mismatch($sformatf("byteenable %b on a write", bus_byteenable));
      end
      if (bus_read || bus_write) begin
        assert ((bus_address - RESET_VECTOR) < MEM_WORDS * 4 && bus_address[1:0] == 2'b00)
        else report_mismatch($sformatf("access to %h outside the memory", bus_address));
      end
      if (bus_read && !first_read_seen) begin
        assert (bus_address == RESET_VECTOR)
        else report_mismatch($sformatf("first fetch from %h", bus_address));
        first_read_seen = 1'b1;
      end
      if (bus_read && !bus_waitrequest && bus_address < DATA_ADDR) begin
        last_fetch_addr = bus_address;
      end
      req_pending  = (bus_read || bus_write) && bus_waitrequest;
      held_address = bus_address;
      held_read    = bus_read;
      held_write   = bus_write;
    end
  end

  initial begin
    reset           = 1'b1;
    req_pending     = 1'b0;
    held_address    = '0;
    held_read       = 1'b0;
    held_write      = 1'b0;
    first_read_seen = 1'b0;
    last_fetch_addr = '0;
    cycles          = 0;
    exp_sum         = D0 + D1 + D2 + D3;
    exp_checksum    = expected_checksum(exp_sum);
    load_memory();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    assert (bus_active) else report_mismatch("active_o low after reset");
    while (bus_active && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (bus_active) begin
      stop_on_error($sformatf("Timeout: the CPU did not halt within %0d cycles",
                              TIMEOUT_CYCLES));
    end else begin
      assert (last_fetch_addr == RESET_VECTOR + 32'(JR_INDEX * 4))
      else report_mismatch($sformatf("halt after fetch from %h, not after the JR",
                                     last_fetch_addr));
      assert (register_v0 == exp_checksum)
      else report_mismatch($sformatf("register_v0 %h, expected %h", register_v0,
                                     exp_checksum));
      assert (wr_count == 1) else report_mismatch($sformatf("%0d bus writes", wr_count));
      assert (last_wr_addr == SUM_ADDR)
      else report_mismatch($sformatf("store to %h, expected %h", last_wr_addr, SUM_ADDR));
      assert (swap_endian(last_wr_data) == exp_sum)
      else report_mismatch($sformatf("stored %h, expected %h", swap_endian(last_wr_data),
                                     exp_sum));
      assert (last_wr_be == 4'hF)
      else report_mismatch($sformatf("store byteenable %b", last_wr_be));
      // Halted CPU stays quiet
      repeat (10) begin
        @(negedge clk);
        assert (!bus_active && !bus_read && !bus_write)
        else report_mismatch("bus activity after halt");
      end
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/mips_pkg.sv
hw/instr_fields_if.sv
hw/mips_fsm.sv
hw/mips_control.sv
hw/mips_ir.sv
hw/mips_pc.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_cpu_bus.sv
sim/tb_clock_gen.sv
sim/avalon_mem_model.sv
sim/mips_cpu_bus_tb.sv
